/* logic/ucode_pkg.sv */
// Shared definitions for the micro-sequenced core
// Word and field widths
// Opcode encodings
// Register and immediate instruction layouts, and their union

`default_nettype none

package ucode_pkg;

    // Word widths
    localparam int INSTR_W = 32;
    localparam int REG_AW  = 4;  // 16 registers
    localparam int DATA_W  = 32;
    localparam int IMM_W   = 16;
    localparam int OPC_W   = 7;  // Opcode sits in the top bits

    // Opcodes, anything else decodes as NOP
    localparam logic [OPC_W-1:0] OP_MOV  = 7'b0000000; // Rd = zext(imm)
    localparam logic [OPC_W-1:0] OP_ADD  = 7'b0110001; // Rd = Rs1 + Rs2
    localparam logic [OPC_W-1:0] OP_SUB  = 7'b0110010; // Rd = Rs1 - Rs2
    localparam logic [OPC_W-1:0] OP_MULI = 7'b0111000; // Rd = Rs * imm, expanded
    localparam logic [OPC_W-1:0] OP_NOP  = 7'b1100100;

    // Register layout for ADD and SUB
    typedef struct packed {
        logic [OPC_W-1:0]                    opcode;
        logic [REG_AW-1:0]                   rd;
        logic [REG_AW-1:0]                   rs1;
        logic [REG_AW-1:0]                   rs2;
        logic [INSTR_W-OPC_W-3*REG_AW-1:0]   spare; // 13 unused bits
    } instr_alu_t;

    // Immediate layout for MOV and MULI
    typedef struct packed {
        logic [OPC_W-1:0]  opcode;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;   // Multiplicand register for MULI
        logic              pad;
        logic [IMM_W-1:0]  imm;
    } instr_imm_t;

    // One fetched word, two views
    typedef union packed {
        instr_alu_t alu;
        instr_imm_t imm;
    } instr_word_u;

endpackage

`default_nettype wire

/* logic/mul_sequencer.sv */
// MULI expansion front end
// Plain words pass through a one-entry output register
// MULI becomes SUB Rd,Rd,Rd for imm 0,
// else MOV Rd,#0 followed by imm x ADD Rd,Rd,Rs
// FSM states idle, clear, move, add with a 16-bit down-counter

`timescale 1ns/100ps
`default_nettype none

module mul_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    // Instruction words in
    input  logic                   in_valid,
    output logic                   in_ready,
    input  ucode_pkg::instr_word_u in_instr,
    // Micro-ops out
    output logic                   uop_valid,
    input  logic                   uop_ready,
    output ucode_pkg::instr_word_u uop_instr
);

    localparam logic [1:0] S_IDLE  = 2'd0; // Output holds a plain word or nothing
    localparam logic [1:0] S_CLEAR = 2'd1; // SUB Rd,Rd,Rd waiting in output
    localparam logic [1:0] S_MOVE  = 2'd2; // MOV Rd,#0 waiting in output
    localparam logic [1:0] S_ADD   = 2'd3; // ADD Rd,Rd,Rs waiting, count left

    logic [1:0]                      state;
    logic [ucode_pkg::IMM_W-1:0]     count;   // ADDs still to issue, incl. current
    logic [ucode_pkg::REG_AW-1:0]    mul_rd;  // Latched destination of the MULI
    logic [ucode_pkg::REG_AW-1:0]    mul_rs;  // Latched source of the MULI
    logic                            run;     // Set one cycle after reset
    logic                            out_free;
    logic                            last_uop;
    logic                            take;
    logic                            is_muli;
    logic                            imm_zero;

    // Build a register-layout word
    function automatic ucode_pkg::instr_word_u mk_alu(
        input logic [ucode_pkg::OPC_W-1:0]  op,
        input logic [ucode_pkg::REG_AW-1:0] rd,
        input logic [ucode_pkg::REG_AW-1:0] rs1,
        input logic [ucode_pkg::REG_AW-1:0] rs2
    );
        ucode_pkg::instr_word_u w;
        w.alu.opcode = op;
        w.alu.rd     = rd;
        w.alu.rs1    = rs1;
        w.alu.rs2    = rs2;
        w.alu.spare  = '0;
        return w;
    endfunction

    // MOV Rd,#0 in the immediate layout
    function automatic ucode_pkg::instr_word_u mk_mov0(
        input logic [ucode_pkg::REG_AW-1:0] rd
    );
        ucode_pkg::instr_word_u w;
        w.imm.opcode = ucode_pkg::OP_MOV;
        w.imm.rd     = rd;
        w.imm.rs1    = '0;
        w.imm.pad    = 1'b0;
        w.imm.imm    = '0;
        return w;
    endfunction

    assign out_free = !uop_valid || uop_ready;          // Output empty or draining now
    assign last_uop = (state == S_CLEAR) ||
                      (state == S_ADD && count == ucode_pkg::IMM_W'(1));
    // New word only when no expansion is left after the current transfer
    assign in_ready = run && out_free && (state == S_IDLE || last_uop);
    assign take     = in_valid && in_ready;
    assign is_muli  = in_instr.imm.opcode == ucode_pkg::OP_MULI;
    assign imm_zero = in_instr.imm.imm == '0;

    // Control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run       <= 1'b0;
            state     <= S_IDLE;
            count     <= '0;
            uop_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (take) begin
                uop_valid <= 1'b1;                      // Every accepted word yields a uop
                if (!is_muli) begin
                    state <= S_IDLE;
                end else if (imm_zero) begin
                    state <= S_CLEAR;
                end else begin
                    state <= S_MOVE;
                    count <= in_instr.imm.imm;          // One ADD per unit of imm
                end
            end else if (uop_valid && uop_ready) begin
                case (state)
                    S_MOVE: state <= S_ADD;             // First ADD follows the MOV
                    S_ADD: begin
                        if (count == ucode_pkg::IMM_W'(1)) begin
                            state     <= S_IDLE;        // Last ADD gone
                            uop_valid <= 1'b0;
                        end else begin
                            count <= count - 1'b1;
                        end
                    end
                    default: begin                      // Idle or clear, output drained
                        state     <= S_IDLE;
                        uop_valid <= 1'b0;
                    end
                endcase
            end
        end
    end

    // Output word and latched operands
    always_ff @(posedge clk) begin
        if (take) begin
            mul_rd <= in_instr.imm.rd;
            mul_rs <= in_instr.imm.rs1;
            if (!is_muli) begin
                uop_instr <= in_instr;                  // Plain word unchanged
            end else if (imm_zero) begin
                uop_instr <= mk_alu(ucode_pkg::OP_SUB, in_instr.imm.rd,
                                    in_instr.imm.rd, in_instr.imm.rd);
            end else begin
                uop_instr <= mk_mov0(in_instr.imm.rd);
            end
        end else if (uop_valid && uop_ready && state == S_MOVE) begin
            // Same ADD word repeats until count runs out
            uop_instr <= mk_alu(ucode_pkg::OP_ADD, mul_rd, mul_rd, mul_rs);
        end
    end

endmodule

`default_nettype wire

/* logic/uop_fifo.sv */
// Synchronous micro-op FIFO
// Circular buffer, pointers one bit wider than the address
// valid/ready on write and read sides, read data straight from memory

`timescale 1ns/100ps
`default_nettype none

module uop_fifo #(
    parameter int FIFO_DEPTH = 4  // Power of two, at least 2
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_valid,
    output logic                          wr_ready,
    input  logic [ucode_pkg::INSTR_W-1:0] wr_data,
    output logic                          rd_valid,
    input  logic                          rd_ready,
    output logic [ucode_pkg::INSTR_W-1:0] rd_data
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [ucode_pkg::INSTR_W-1:0] mem [FIFO_DEPTH];
    logic [AW:0]                   wr_ptr;   // MSB is the wrap bit
    logic [AW:0]                   rd_ptr;
    logic                          full;
    logic                          empty;
    logic                          do_wr;
    logic                          do_rd;

    assign empty = wr_ptr == rd_ptr;
    // Same slot, opposite wrap
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign rd_valid = !empty;
    assign wr_ready = !full || rd_ready;                // Full but draining takes a word
    assign rd_data  = mem[rd_ptr[AW-1:0]];
    assign do_wr    = wr_valid && wr_ready;
    assign do_rd    = rd_valid && rd_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
// Execution unit
// 16 x 32-bit register file reset to zero
// MOV / ADD / SUB with wrap-around
// NOP and unknown opcodes dropped
// One-entry writeback register held until taken

`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ex_valid,
    output logic                         ex_ready,
    input  ucode_pkg::instr_word_u       ex_instr,
    output logic                         wb_valid,
    input  logic                         wb_ready,
    output logic [ucode_pkg::REG_AW-1:0] wb_reg,
    output logic [ucode_pkg::DATA_W-1:0] wb_data
);

    localparam int NREG = 2 ** ucode_pkg::REG_AW;

    logic [ucode_pkg::DATA_W-1:0] rf [NREG];
    logic                         accept;
    logic                         do_wr;    // Micro-op writes a register
    logic [ucode_pkg::REG_AW-1:0] dst;
    logic [ucode_pkg::DATA_W-1:0] result;

    assign ex_ready = !wb_valid || wb_ready;            // Room for the next writeback
    assign accept   = ex_valid && ex_ready;

    // Decode through the layout that matches the opcode
    always_comb begin
        do_wr  = 1'b0;
        dst    = ex_instr.alu.rd;                       // Same bits in both layouts
        result = '0;
        case (ex_instr.alu.opcode)
            ucode_pkg::OP_MOV: begin
                do_wr  = 1'b1;
                result = ucode_pkg::DATA_W'(ex_instr.imm.imm); // Zero-extend
            end
            ucode_pkg::OP_ADD: begin
                do_wr  = 1'b1;
                result = rf[ex_instr.alu.rs1] + rf[ex_instr.alu.rs2];
            end
            ucode_pkg::OP_SUB: begin
                do_wr  = 1'b1;
                result = rf[ex_instr.alu.rs1] - rf[ex_instr.alu.rs2]; // Wraps on underflow
            end
            default: begin
                do_wr = 1'b0;                           // NOP, MULI, unknown
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NREG; i++) begin
                rf[i] <= '0;
            end
            wb_valid <= 1'b0;
        end else begin
            if (wb_ready) begin
                wb_valid <= 1'b0;                       // Pending writeback taken
            end
            if (accept && do_wr) begin
                rf[dst]  <= result;
                wb_valid <= 1'b1;
            end
        end
    end

    // Writeback payload
    always_ff @(posedge clk) begin
        if (accept && do_wr) begin
            wb_reg  <= dst;
            wb_data <= result;
        end
    end

endmodule

`default_nettype wire

/* logic/ucode_core.sv */
// Core top level
// Sequencer feeds the micro-op FIFO, FIFO feeds the execution unit
// FIFO_DEPTH set here and handed to the FIFO

`timescale 1ns/100ps
`default_nettype none

module ucode_core #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  ucode_pkg::instr_word_u       in_instr,
    output logic                         wb_valid,
    input  logic                         wb_ready,
    output logic [ucode_pkg::REG_AW-1:0] wb_reg,
    output logic [ucode_pkg::DATA_W-1:0] wb_data
);

    // Sequencer to FIFO
    logic                   uop_valid;
    logic                   uop_ready;
    ucode_pkg::instr_word_u uop_instr;
    // FIFO to execution unit
    logic                   ex_valid;
    logic                   ex_ready;
    ucode_pkg::instr_word_u ex_instr;

    mul_sequencer mul_sequencer_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .uop_valid (uop_valid),
        .uop_ready (uop_ready),
        .uop_instr (uop_instr)
    );

    uop_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uop_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (uop_valid),
        .wr_ready (uop_ready),
        .wr_data  (uop_instr),      // Stored as a flat word
        .rd_valid (ex_valid),
        .rd_ready (ex_ready),
        .rd_data  (ex_instr)
    );

    exec_unit exec_unit_i (
        .clk      (clk),
        .rst      (rst),
        .ex_valid (ex_valid),
        .ex_ready (ex_ready),
        .ex_instr (ex_instr),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

/* bench/ucode_ref.svh */
// Reference model of the core
// Model register file and queue of expected writebacks
// MULI expanded literally, 32-bit wrap-around arithmetic

`ifndef UCODE_REF_SVH
`define UCODE_REF_SVH

logic [31:0] model_rf [16];   // Mirrors the DUT register file
logic [35:0] exp_q [$];       // {reg, data} in writeback order

// All model registers back to 0
function automatic void model_reset();
    for (int r = 0; r < 16; r++) begin
        model_rf[r] = 32'h0;
    end
endfunction

// Write one model register and queue its writeback
function automatic void model_write(input logic [3:0] rd, input logic [31:0] value);
    model_rf[rd] = value;
    exp_q.push_back({rd, value});
endfunction

// Expected writebacks of one accepted instruction word
function automatic void predict_wb(input logic [31:0] word);
    logic [6:0]  op;
    logic [3:0]  rd;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [15:0] imm;
    int          k;
    op  = word[31:25];
    rd  = word[24:21];
    rs1 = word[20:17];
    rs2 = word[16:13];   // Register layout only
    imm = word[15:0];    // Immediate layout only
    case (op)
        ucode_pkg::OP_MOV: model_write(rd, {16'h0, imm});
        ucode_pkg::OP_ADD: model_write(rd, model_rf[rs1] + model_rf[rs2]);
        ucode_pkg::OP_SUB: model_write(rd, model_rf[rs1] - model_rf[rs2]);
        ucode_pkg::OP_MULI: begin
            if (imm == 16'h0) begin
                model_write(rd, model_rf[rd] - model_rf[rd]);   // SUB Rd,Rd,Rd
            end else begin
                model_write(rd, 32'h0);                         // MOV Rd,#0
                for (k = 0; k < int'(imm); k++) begin
                    model_write(rd, model_rf[rd] + model_rf[rs1]); // ADD Rd,Rd,Rs
                end
            end
        end
        default: ;   // NOP and unknown opcodes leave no writeback
    endcase
endfunction

`endif

/* bench/ucode_tb.sv */
// Testbench for ucode_core
// Directed words, MULI sweep, NOP / unknown opcodes, then a random mixed stream
// Random wb_ready back-pressure and in_valid gaps in the random part
// Reference model predicts writebacks and a comparing process checks each transfer
// Watchdog bounds the run

`timescale 1ns/100ps
`default_nettype none

module ucode_tb;

    logic                         clk;
    logic                         rst;
    logic                         in_valid;
    logic                         in_ready;
    logic [ucode_pkg::INSTR_W-1:0] in_instr;
    logic                         wb_valid;
    logic                         wb_ready;
    logic [ucode_pkg::REG_AW-1:0] wb_reg;
    logic [ucode_pkg::DATA_W-1:0] wb_data;

    logic [31:0] stream [$];   // Words to send in order
    bit          bp_pat [1024]; // wb_ready pattern for the random part
    bit          bp_on;
    int          rand_start;    // Index of the first random word
    int          n_words;
    int          errors;
    int          wb_seen;
    int          cyc;

    `include "ucode_ref.svh"

    ucode_core #(
        .FIFO_DEPTH (4)
    ) ucode_core_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_instr (in_instr),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data)
    );

    always #2 clk = ~clk;   // 4 ns period

    // Word encoders
    function automatic logic [31:0] imm_word(input logic [6:0] op, input logic [3:0] rd,
                                             input logic [3:0] rs, input logic [15:0] imm);
        return {op, rd, rs, 1'b0, imm};
    endfunction

    function automatic logic [31:0] alu_word(input logic [6:0] op, input logic [3:0] rd,
                                             input logic [3:0] rs1, input logic [3:0] rs2);
        return {op, rd, rs1, rs2, 13'h0};
    endfunction

    // Directed words followed by a random mix
    task automatic build_stream();
        int          k;
        int          sel;
        logic [3:0]  rd;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [15:0] imm;
        stream.push_back(alu_word(ucode_pkg::OP_ADD, 4'd1, 4'd2, 4'd3)); // Reset regs read 0
        stream.push_back(imm_word(ucode_pkg::OP_MOV, 4'd2, 4'd0, 16'd7));
        stream.push_back(imm_word(ucode_pkg::OP_MOV, 4'd3, 4'd0, 16'hffff));
        stream.push_back(alu_word(ucode_pkg::OP_ADD, 4'd4, 4'd2, 4'd3));
        stream.push_back(alu_word(ucode_pkg::OP_SUB, 4'd5, 4'd2, 4'd3)); // 7 - 0xffff wraps
        stream.push_back(alu_word(ucode_pkg::OP_SUB, 4'd6, 4'd0, 4'd4)); // 0 - x wraps
        stream.push_back(imm_word(ucode_pkg::OP_MULI, 4'd4, 4'd3, 16'd0)); // Clears nonzero R4
        for (k = 1; k <= 20; k++) begin
            rd = 4'(8 + k % 4);
            ra = (k % 2 == 1) ? 4'd2 : 4'd3;
            stream.push_back(imm_word(ucode_pkg::OP_MULI, rd, ra, 16'(k)));
        end
        stream.push_back(imm_word(ucode_pkg::OP_MOV, 4'd12, 4'd0, 16'd5));
        stream.push_back(imm_word(ucode_pkg::OP_MULI, 4'd12, 4'd12, 16'd3)); // Rd == Rs
        stream.push_back(alu_word(ucode_pkg::OP_NOP, 4'd1, 4'd2, 4'd3));
        stream.push_back(alu_word(7'h7f, 4'd1, 4'd2, 4'd3));                 // Unknown opcode
        stream.push_back(imm_word(ucode_pkg::OP_MOV, 4'd13, 4'd0, 16'h1234));
        stream.push_back(alu_word(ucode_pkg::OP_NOP, 4'd0, 4'd0, 4'd0));
        stream.push_back(alu_word(ucode_pkg::OP_ADD, 4'd14, 4'd13, 4'd2));
        rand_start = stream.size();
        for (k = 0; k < 160; k++) begin
            sel = $urandom % 8;
            rd  = 4'($urandom);
            ra  = 4'($urandom);
            rb  = 4'($urandom);
            imm = 16'($urandom);
            case (sel)
                0, 1: stream.push_back(imm_word(ucode_pkg::OP_MOV, rd, 4'd0, imm));
                2, 3: stream.push_back(alu_word(ucode_pkg::OP_ADD, rd, ra, rb));
                4:    stream.push_back(alu_word(ucode_pkg::OP_SUB, rd, ra, rb));
                5:    stream.push_back(imm_word(ucode_pkg::OP_MULI, rd, ra, 16'(imm % 6)));
                6:    stream.push_back(alu_word(ucode_pkg::OP_NOP, rd, ra, rb));
                default: stream.push_back(alu_word(7'h55, rd, ra, rb)); // Not an opcode
            endcase
        end
        for (k = 0; k < 1024; k++) begin
            bp_pat[k] = ($urandom % 4) != 0;   // About one stall cycle in four
        end
    endtask

    // Hold one word on the input until the handshake takes it
    task automatic send_word(input logic [31:0] word);
        in_valid = 1'b1;
        in_instr = word;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);     // Transfer happens at this edge
        #1;
        predict_wb(word);
        in_valid = 1'b0;
        in_instr = '0;
    endtask

    // wb_ready driven just after each rising edge
    always @(posedge clk) begin
        #1;
        cyc++;
        wb_ready = bp_on ? bp_pat[cyc % 1024] : 1'b1;
    end

    // Compare each writeback transfer with the head of the expected queue
    always @(negedge clk) begin : compare_wb
        logic [35:0] want;
        if (!rst && wb_valid && wb_ready) begin
            wb_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Time %0t: writeback to r%0d = %h with nothing expected",
                         $time, wb_reg, wb_data);
            end else begin
                want = exp_q.pop_front();
                if (wb_reg !== want[35:32]) begin
                    errors++;
                    $display("MISMATCH time %0t wb_reg expected %0d actual %0d",
                             $time, want[35:32], wb_reg);
                end
                if (wb_data !== want[31:0]) begin
                    errors++;
                    $display("MISMATCH time %0t wb_data expected %h actual %h",
                             $time, want[31:0], wb_data);
                end
            end
        end
    end

    // Watchdog with a budget of 40 cycles per word plus slack
    initial begin : watchdog
        wait (n_words > 0);
        #(n_words * 40 * 4 + 2000);
        $display("Timeout: run did not end within the budget for %0d words", n_words);
        $display("Test FAILED");
        $finish;
    end

    initial begin : main
        int i;
        int gap;
        void'($urandom(32'ha47d_788e));
        clk      = 1'b0;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        wb_ready = 1'b0;
        bp_on    = 1'b0;
        errors   = 0;
        wb_seen  = 0;
        cyc      = 0;
        model_reset();
        build_stream();
        n_words = stream.size();
        repeat (4) @(posedge clk);
        #1;
        if (in_ready !== 1'b0 || wb_valid !== 1'b0) begin
            errors++;
            $display("in_ready or wb_valid not low during reset");
        end
        rst = 1'b0;
        repeat (3) begin   // Idle cycles where any writeback is unexpected
            @(posedge clk);
            #1;
        end
        for (i = 0; i < n_words; i++) begin
            if (i == rand_start) begin
                bp_on = 1'b1;
            end
            gap = (bp_on && $urandom % 4 == 0) ? 1 + $urandom % 3 : 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            send_word(stream[i]);
        end
        i = 0;
        while (exp_q.size() != 0 && i < 5000) begin   // Drain the pipeline
            @(negedge clk);
            i++;
        end
        repeat (20) @(posedge clk);   // Room for stray extra writebacks
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected writebacks never appeared", exp_q.size());
        end
        $display("Words %0d, writebacks %0d, errors %0d", n_words, wb_seen, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+bench
logic/ucode_pkg.sv
logic/mul_sequencer.sv
logic/uop_fifo.sv
logic/exec_unit.sv
logic/ucode_core.sv
bench/ucode_tb.sv

/* Makefile */
# Verilator build and run of the ucode_core testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module ucode_tb -Mdir obj_dir
	./obj_dir/Vucode_tb 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
